// ==== hw/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data and instruction word width
`define RV_XLEN 32

// Register file address width, x0 to x31
`define RV_REG_AW 5

// Instruction memory, in words
`define RV_IMEM_AW 6
`define RV_IMEM_DEPTH (1 << `RV_IMEM_AW)

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8  // LUI result
    } alu_op_e;

    // Funct3 of OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Funct3 of BRANCH
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000; // SUB

endpackage

// ==== hw/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    // ALU operand A source
    typedef enum logic {
        OPA_RS1 = 1'b0,
        OPA_PC  = 1'b1
    } op_a_sel_e;

    // ALU operand B source
    typedef enum logic [1:0] {
        OPB_RS2  = 2'b00,
        OPB_IMM  = 2'b01,
        OPB_FOUR = 2'b10  // Link value with PC on A
    } op_b_sel_e;

endpackage

// ==== hw/rv_fetch.sv ====
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_fetch (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   imem_we_i,
    input  logic [`RV_IMEM_AW-1:0] imem_waddr_i,
    input  logic [`RV_XLEN-1:0]    imem_wdata_i,
    input  logic                   redirect_i,
    input  logic [`RV_XLEN-1:0]    redirect_pc_i,
    output logic                   if_id_vld_o,
    output logic [`RV_XLEN-1:0]    if_id_pc_o,
    output logic [`RV_XLEN-1:0]    if_id_instr_o
);

    logic [`RV_XLEN-1:0] imem_q [`RV_IMEM_DEPTH];
    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] pc_d;
    logic [`RV_XLEN-1:0] instr;
    logic                fetch_ok;

    // Load port, filled before the program runs
    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            imem_q[imem_waddr_i] <= imem_wdata_i;
        end
    end

    assign instr = imem_q[pc_q[`RV_IMEM_AW+1:2]]; // Word address

    // Not-taken prediction, execute overrides
    always_comb begin
        if (redirect_i) begin
            pc_d = redirect_pc_i;
        end else if (imem_we_i) begin
            pc_d = pc_q;                     // Hold while loading
        end else begin
            pc_d = pc_q + `RV_XLEN'(4);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= `RV_RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign fetch_ok = !redirect_i && !imem_we_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            if_id_vld_o <= 1'b0;
        end else begin
            if_id_vld_o <= fetch_ok;         // Bubble on redirect or load
        end
    end

    always_ff @(posedge clk_i) begin
        if_id_pc_o    <= pc_q;
        if_id_instr_o <= instr;
    end

    // Targets from execute must keep the PC on a word
    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pc_q[1:0] == 2'b00);

endmodule

// ==== hw/rv_decode.sv ====
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_decode (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   if_id_vld_i,
    input  logic [`RV_XLEN-1:0]    if_id_pc_i,
    input  logic [`RV_XLEN-1:0]    if_id_instr_i,
    input  logic                   flush_i,
    input  logic                   wb_wren_i,
    input  logic [`RV_REG_AW-1:0]  wb_rd_i,
    input  logic [`RV_XLEN-1:0]    wb_data_i,
    output logic                   id_ex_vld_o,
    output logic                   id_ex_wren_o,
    output logic [`RV_REG_AW-1:0]  id_ex_rd_o,
    output logic [`RV_REG_AW-1:0]  id_ex_rs1_o,
    output logic [`RV_REG_AW-1:0]  id_ex_rs2_o,
    output logic [`RV_XLEN-1:0]    id_ex_rs1_data_o,
    output logic [`RV_XLEN-1:0]    id_ex_rs2_data_o,
    output logic [`RV_XLEN-1:0]    id_ex_imm_o,
    output logic [`RV_XLEN-1:0]    id_ex_pc_o,
    output rv_isa_pkg::alu_op_e    id_ex_alu_op_o,
    output rv_pipe_pkg::op_a_sel_e id_ex_op_a_sel_o,
    output rv_pipe_pkg::op_b_sel_e id_ex_op_b_sel_o,
    output logic                   id_ex_is_branch_o,
    output logic                   id_ex_branch_ne_o,
    output logic                   id_ex_is_jal_o
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rd, rs1, rs2;
    logic [`RV_XLEN-1:0]   imm_i, imm_b, imm_u, imm_j;
    alu_op_e               alu_fn;
    logic                  fn_ok, is_shift, keep;
    logic                  dec_vld, dec_wren, dec_is_branch, dec_is_jal;
    alu_op_e               dec_alu_op;
    op_a_sel_e             dec_op_a_sel;
    op_b_sel_e             dec_op_b_sel;
    logic [`RV_XLEN-1:0]   dec_imm;
    logic [`RV_XLEN-1:0]   rf_q [1:(1 << `RV_REG_AW) - 1]; // x0 has no storage

    function automatic logic [`RV_XLEN-1:0] rf_read(logic [`RV_REG_AW-1:0] addr);
        if (addr == '0) return '0;
        if (wb_wren_i && wb_rd_i == addr) return wb_data_i; // Write-through
        return rf_q[addr];
    endfunction

    assign opcode = opcode_e'(if_id_instr_i[6:0]);
    assign rd     = if_id_instr_i[11:7];
    assign funct3 = if_id_instr_i[14:12];
    assign rs1    = if_id_instr_i[19:15];
    assign rs2    = if_id_instr_i[24:20];
    assign funct7 = if_id_instr_i[31:25];

    assign imm_i = {{20{if_id_instr_i[31]}}, if_id_instr_i[31:20]};
    assign imm_b = {{20{if_id_instr_i[31]}}, if_id_instr_i[7], if_id_instr_i[30:25],
                    if_id_instr_i[11:8], 1'b0};
    assign imm_u = {if_id_instr_i[31:12], 12'b0};
    assign imm_j = {{12{if_id_instr_i[31]}}, if_id_instr_i[19:12], if_id_instr_i[20],
                    if_id_instr_i[30:21], 1'b0};

    always_comb begin
        alu_fn = ALU_ADD;
        fn_ok  = 1'b1;
        case (funct3)
            F3_ADD_SUB: alu_fn = ALU_ADD;
            F3_SLL:     alu_fn = ALU_SLL;
            F3_SLT:     alu_fn = ALU_SLT;
            F3_XOR:     alu_fn = ALU_XOR;
            F3_SRL:     alu_fn = ALU_SRL;
            F3_OR:      alu_fn = ALU_OR;
            F3_AND:     alu_fn = ALU_AND;
            default:    fn_ok  = 1'b0;   // SLTU
        endcase
    end

    assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SRL);

    always_comb begin
        dec_vld       = 1'b0;
        dec_wren      = 1'b0;
        dec_is_branch = 1'b0;
        dec_is_jal    = 1'b0;
        dec_alu_op    = alu_fn;
        dec_op_a_sel  = OPA_RS1;
        dec_op_b_sel  = OPB_RS2;
        dec_imm       = imm_i;
        case (opcode)
            OPC_OP: begin
                // SRA and the other funct7 forms stay undecoded
                dec_vld  = fn_ok && (funct7 == F7_BASE ||
                           (funct7 == F7_ALT && funct3 == F3_ADD_SUB));
                dec_wren = 1'b1;
                if (funct7 == F7_ALT) dec_alu_op = ALU_SUB;
            end
            OPC_OP_IMM: begin
                dec_vld      = fn_ok && (!is_shift || funct7 == F7_BASE);
                dec_wren     = 1'b1;
                dec_op_b_sel = OPB_IMM;
            end
            OPC_LUI: begin
                dec_vld      = 1'b1;
                dec_wren     = 1'b1;
                dec_alu_op   = ALU_PASS_B;
                dec_op_b_sel = OPB_IMM;
                dec_imm      = imm_u;
            end
            OPC_BRANCH: begin
                dec_vld       = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                dec_is_branch = 1'b1;
                dec_imm       = imm_b;
            end
            OPC_JAL: begin
                dec_vld      = 1'b1;
                dec_wren     = 1'b1;
                dec_is_jal   = 1'b1;
                dec_alu_op   = ALU_ADD;    // PC + 4 link
                dec_op_a_sel = OPA_PC;
                dec_op_b_sel = OPB_FOUR;
                dec_imm      = imm_j;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (wb_wren_i && wb_rd_i != '0) rf_q[wb_rd_i] <= wb_data_i;
    end

    assign keep = if_id_vld_i && dec_vld && !flush_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            id_ex_vld_o       <= 1'b0;
            id_ex_wren_o      <= 1'b0;
            id_ex_is_branch_o <= 1'b0;
            id_ex_is_jal_o    <= 1'b0;
        end else begin
            id_ex_vld_o       <= keep;
            id_ex_wren_o      <= keep && dec_wren && (rd != '0);
            id_ex_is_branch_o <= keep && dec_is_branch;
            id_ex_is_jal_o    <= keep && dec_is_jal;
        end
    end

    always_ff @(posedge clk_i) begin
        id_ex_rd_o        <= rd;
        id_ex_rs1_o       <= rs1;
        id_ex_rs2_o       <= rs2;
        id_ex_rs1_data_o  <= rf_read(rs1);
        id_ex_rs2_data_o  <= rf_read(rs2);
        id_ex_imm_o       <= dec_imm;
        id_ex_pc_o        <= if_id_pc_i;
        id_ex_alu_op_o    <= dec_alu_op;
        id_ex_op_a_sel_o  <= dec_op_a_sel;
        id_ex_op_b_sel_o  <= dec_op_b_sel;
        id_ex_branch_ne_o <= (funct3 == F3_BNE);
    end

    // Writebacks from execute never target x0
    a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_wren_i |-> wb_rd_i != '0);

endmodule

// ==== hw/rv_execute.sv ====
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_execute (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   id_ex_vld_i,
    input  logic                   id_ex_wren_i,
    input  logic [`RV_REG_AW-1:0]  id_ex_rd_i,
    input  logic [`RV_REG_AW-1:0]  id_ex_rs1_i,
    input  logic [`RV_REG_AW-1:0]  id_ex_rs2_i,
    input  logic [`RV_XLEN-1:0]    id_ex_rs1_data_i,
    input  logic [`RV_XLEN-1:0]    id_ex_rs2_data_i,
    input  logic [`RV_XLEN-1:0]    id_ex_imm_i,
    input  logic [`RV_XLEN-1:0]    id_ex_pc_i,
    input  rv_isa_pkg::alu_op_e    id_ex_alu_op_i,
    input  rv_pipe_pkg::op_a_sel_e id_ex_op_a_sel_i,
    input  rv_pipe_pkg::op_b_sel_e id_ex_op_b_sel_i,
    input  logic                   id_ex_is_branch_i,
    input  logic                   id_ex_branch_ne_i,
    input  logic                   id_ex_is_jal_i,
    output logic                   redirect_o,
    output logic [`RV_XLEN-1:0]    redirect_pc_o,
    output logic                   retire_vld_o,
    output logic [`RV_XLEN-1:0]    retire_pc_o,
    output logic                   retire_wren_o,
    output logic [`RV_REG_AW-1:0]  retire_rd_o,
    output logic [`RV_XLEN-1:0]    retire_data_o
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [`RV_XLEN-1:0] rs1_fwd, rs2_fwd;
    logic [`RV_XLEN-1:0] op_a, op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [4:0]          shamt;
    logic                br_taken;

    // EX/WB is the only forwarding source
    assign rs1_fwd = (retire_wren_o && retire_rd_o == id_ex_rs1_i) ? retire_data_o
                                                                   : id_ex_rs1_data_i;
    assign rs2_fwd = (retire_wren_o && retire_rd_o == id_ex_rs2_i) ? retire_data_o
                                                                   : id_ex_rs2_data_i;

    assign op_a = (id_ex_op_a_sel_i == OPA_PC) ? id_ex_pc_i : rs1_fwd;

    always_comb begin
        case (id_ex_op_b_sel_i)
            OPB_IMM:  op_b = id_ex_imm_i;
            OPB_FOUR: op_b = `RV_XLEN'(4);
            default:  op_b = rs2_fwd;
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex_alu_op_i)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // BEQ or BNE by the inverted compare
    assign br_taken = id_ex_is_branch_i && ((rs1_fwd == rs2_fwd) != id_ex_branch_ne_i);

    assign redirect_o    = id_ex_vld_i && (id_ex_is_jal_i || br_taken);
    assign redirect_pc_o = id_ex_pc_i + id_ex_imm_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            retire_vld_o  <= 1'b0;
            retire_wren_o <= 1'b0;
        end else begin
            retire_vld_o  <= id_ex_vld_i;
            retire_wren_o <= id_ex_wren_i;
        end
    end

    always_ff @(posedge clk_i) begin
        retire_pc_o   <= id_ex_pc_i;
        retire_rd_o   <= id_ex_rd_i;
        retire_data_o <= alu_res;
    end

    // Decode hands over a bubble after a redirect
    a_redirect_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
        redirect_o |=> !id_ex_vld_i);

endmodule

// ==== hw/rv_core_top.sv ====
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_core_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   imem_we_i,
    input  logic [`RV_IMEM_AW-1:0] imem_waddr_i,
    input  logic [`RV_XLEN-1:0]    imem_wdata_i,
    output logic                   retire_vld_o,
    output logic [`RV_XLEN-1:0]    retire_pc_o,
    output logic                   retire_wren_o,
    output logic [`RV_REG_AW-1:0]  retire_rd_o,
    output logic [`RV_XLEN-1:0]    retire_data_o
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic                  if_id_vld;
    logic [`RV_XLEN-1:0]   if_id_pc, if_id_instr;
    logic                  redirect;
    logic [`RV_XLEN-1:0]   redirect_pc;

    // ID/EX register contents
    logic                  id_ex_vld, id_ex_wren;
    logic [`RV_REG_AW-1:0] id_ex_rd, id_ex_rs1, id_ex_rs2;
    logic [`RV_XLEN-1:0]   id_ex_rs1_data, id_ex_rs2_data, id_ex_imm, id_ex_pc;
    alu_op_e               id_ex_alu_op;
    op_a_sel_e             id_ex_op_a_sel;
    op_b_sel_e             id_ex_op_b_sel;
    logic                  id_ex_is_branch, id_ex_branch_ne, id_ex_is_jal;

    rv_fetch i_fetch (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .imem_we_i     (imem_we_i),
        .imem_waddr_i  (imem_waddr_i),
        .imem_wdata_i  (imem_wdata_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .if_id_vld_o   (if_id_vld),
        .if_id_pc_o    (if_id_pc),
        .if_id_instr_o (if_id_instr)
    );

    rv_decode i_decode (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .if_id_vld_i       (if_id_vld),
        .if_id_pc_i        (if_id_pc),
        .if_id_instr_i     (if_id_instr),
        .flush_i           (redirect),
        .wb_wren_i         (retire_wren_o),  // Writeback is the retire trace
        .wb_rd_i           (retire_rd_o),
        .wb_data_i         (retire_data_o),
        .id_ex_vld_o       (id_ex_vld),
        .id_ex_wren_o      (id_ex_wren),
        .id_ex_rd_o        (id_ex_rd),
        .id_ex_rs1_o       (id_ex_rs1),
        .id_ex_rs2_o       (id_ex_rs2),
        .id_ex_rs1_data_o  (id_ex_rs1_data),
        .id_ex_rs2_data_o  (id_ex_rs2_data),
        .id_ex_imm_o       (id_ex_imm),
        .id_ex_pc_o        (id_ex_pc),
        .id_ex_alu_op_o    (id_ex_alu_op),
        .id_ex_op_a_sel_o  (id_ex_op_a_sel),
        .id_ex_op_b_sel_o  (id_ex_op_b_sel),
        .id_ex_is_branch_o (id_ex_is_branch),
        .id_ex_branch_ne_o (id_ex_branch_ne),
        .id_ex_is_jal_o    (id_ex_is_jal)
    );

    rv_execute i_execute (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .id_ex_vld_i       (id_ex_vld),
        .id_ex_wren_i      (id_ex_wren),
        .id_ex_rd_i        (id_ex_rd),
        .id_ex_rs1_i       (id_ex_rs1),
        .id_ex_rs2_i       (id_ex_rs2),
        .id_ex_rs1_data_i  (id_ex_rs1_data),
        .id_ex_rs2_data_i  (id_ex_rs2_data),
        .id_ex_imm_i       (id_ex_imm),
        .id_ex_pc_i        (id_ex_pc),
        .id_ex_alu_op_i    (id_ex_alu_op),
        .id_ex_op_a_sel_i  (id_ex_op_a_sel),
        .id_ex_op_b_sel_i  (id_ex_op_b_sel),
        .id_ex_is_branch_i (id_ex_is_branch),
        .id_ex_branch_ne_i (id_ex_branch_ne),
        .id_ex_is_jal_i    (id_ex_is_jal),
        .redirect_o        (redirect),
        .redirect_pc_o     (redirect_pc),
        .retire_vld_o      (retire_vld_o),
        .retire_pc_o       (retire_pc_o),
        .retire_wren_o     (retire_wren_o),
        .retire_rd_o       (retire_rd_o),
        .retire_data_o     (retire_data_o)
    );

endmodule

// ==== dv/rv_retire_checker.sv ====
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_retire_checker #(
    parameter int NUM_RET     = 1,
    parameter int CYCLE_LIMIT = 100
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  imem_we_i,
    input  logic                  retire_vld_i,
    input  logic [`RV_XLEN-1:0]   retire_pc_i,
    input  logic                  retire_wren_i,
    input  logic [`RV_REG_AW-1:0] retire_rd_i,
    input  logic [`RV_XLEN-1:0]   retire_data_i,
    input  logic [`RV_XLEN-1:0]   exp_pc_i   [NUM_RET],
    input  logic                  exp_wren_i [NUM_RET],
    input  logic [`RV_REG_AW-1:0] exp_rd_i   [NUM_RET],
    input  logic [`RV_XLEN-1:0]   exp_data_i [NUM_RET],
    output logic                  done_o,
    output int                    checked_o,
    output int                    errors_o
);

    int idx;    // Next expected retirement
    int cycles;

    task automatic check_field(input string name, input logic [`RV_XLEN-1:0] expected,
                               input logic [`RV_XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s at entry %0d, expected %h, actual %h",
                     name, idx, expected, actual);
            errors_o++;
        end
    endtask

    task automatic compare_retire();
        if (idx >= NUM_RET) begin
            $display("Unexpected retirement at pc %h after the last table entry", retire_pc_i);
            errors_o++;
        end else begin
            check_field("retire_pc_o", exp_pc_i[idx], retire_pc_i);
            check_field("retire_wren_o", `RV_XLEN'(exp_wren_i[idx]), `RV_XLEN'(retire_wren_i));
            // Rd and data only matter when the register file is written
            if (exp_wren_i[idx]) begin
                check_field("retire_rd_o", `RV_XLEN'(exp_rd_i[idx]), `RV_XLEN'(retire_rd_i));
                check_field("retire_data_o", exp_data_i[idx], retire_data_i);
            end
            idx++;
            checked_o++;
        end
    endtask

    // Retire trace is registered, so the falling edge sees settled values
    initial begin
        idx       = 0;
        cycles    = 0;
        checked_o = 0;
        errors_o  = 0;
        done_o    = 1'b0;
        forever begin
            @(negedge clk_i);
            if (!rst_ni || imem_we_i) begin
                if (retire_vld_i) begin
                    $display("A retirement appeared during reset or program loading");
                    errors_o++;
                end
            end else if (retire_vld_i) begin
                compare_retire();
            end
            if (rst_ni && !done_o) begin
                cycles++;
                if (idx >= NUM_RET) begin
                    done_o = 1'b1;
                end else if (cycles >= CYCLE_LIMIT) begin
                    $display("Timeout after %0d cycles, retirement %0d of %0d never arrived",
                             cycles, idx, NUM_RET);
                    errors_o++;
                    done_o = 1'b1;
                end
            end
        end
    end

endmodule

// ==== dv/tb_rv_core.sv ====
`timescale 1ns/1ns
`include "rv_consts.svh"

module tb_rv_core;

    localparam int PROG_LEN    = 19;
    localparam int NUM_RET     = 18;
    localparam int JAL_REPEATS = 3;    // Retirements of the final self loop
    localparam int CYCLE_LIMIT = PROG_LEN + NUM_RET * 3 + 20;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    logic                   clk;
    logic                   rst_n;
    logic                   imem_we;
    logic [`RV_IMEM_AW-1:0] imem_waddr;
    logic [`RV_XLEN-1:0]    imem_wdata;
    logic                   retire_vld;
    logic [`RV_XLEN-1:0]    retire_pc;
    logic                   retire_wren;
    logic [`RV_REG_AW-1:0]  retire_rd;
    logic [`RV_XLEN-1:0]    retire_data;
    logic                   done;
    int                     checked;
    int                     errors;

    logic [`RV_XLEN-1:0]   prog     [PROG_LEN];
    logic [`RV_XLEN-1:0]   exp_pc   [NUM_RET];
    logic                  exp_wren [NUM_RET];
    logic [`RV_REG_AW-1:0] exp_rd   [NUM_RET];
    logic [`RV_XLEN-1:0]   exp_data [NUM_RET];
    logic [`RV_XLEN-1:0]   xr       [32];  // Architectural register model
    int                    prog_len;
    int                    num_exp;
    integer                seed;

    function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] op_imm_word(input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [31:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // Appends one program word and, if it retires, its expected trace entry
    task automatic add_insn(input logic [31:0] word, input logic retires,
                            input logic [4:0] rd, input logic [31:0] data);
        prog[prog_len] = word;
        if (retires) begin
            exp_pc[num_exp]   = 32'(prog_len * 4);
            exp_wren[num_exp] = (rd != 5'd0);
            exp_rd[num_exp]   = rd;
            exp_data[num_exp] = data;
            num_exp++;
            if (rd != 5'd0) xr[rd] = data;
        end
        prog_len++;
    endtask

    task automatic build_program();
        logic [31:0] rnd;
        logic [31:0] imm_a;
        logic [31:0] imm_b;
        seed     = 32'h7a6d_5b97;
        rnd      = $random(seed);
        imm_a    = {{20{rnd[11]}}, rnd[11:0]};
        rnd      = $random(seed);
        imm_b    = {{20{rnd[11]}}, rnd[11:0]};
        prog_len = 0;
        num_exp  = 0;
        add_insn(op_imm_word(F3_ADD, 5'd1, 5'd0, imm_a), 1'b1, 5'd1, imm_a);
        add_insn(op_imm_word(F3_ADD, 5'd2, 5'd1, imm_b), 1'b1, 5'd2, xr[1] + imm_b);
        add_insn(op_word(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, xr[1] + xr[2]);
        add_insn(op_word(F7_SUB, F3_ADD, 5'd4, 5'd3, 5'd1), 1'b1, 5'd4, xr[3] - xr[1]);
        add_insn(op_word(F7_BASE, F3_AND, 5'd5, 5'd4, 5'd2), 1'b1, 5'd5, xr[4] & xr[2]);
        add_insn(op_word(F7_BASE, F3_OR, 5'd6, 5'd5, 5'd3), 1'b1, 5'd6, xr[5] | xr[3]);
        add_insn(op_word(F7_BASE, F3_XOR, 5'd7, 5'd6, 5'd4), 1'b1, 5'd7, xr[6] ^ xr[4]);
        add_insn(lui_word(5'd8, 20'h80001), 1'b1, 5'd8, 32'h8000_1000);
        add_insn(op_imm_word(F3_SLL, 5'd9, 5'd8, 32'd3), 1'b1, 5'd9, xr[8] << 3);
        add_insn(op_word(F7_BASE, F3_SRL, 5'd10, 5'd8, 5'd1), 1'b1, 5'd10,
                 xr[8] >> xr[1][4:0]);
        add_insn(op_word(F7_BASE, F3_SLT, 5'd11, 5'd8, 5'd9), 1'b1, 5'd11,
                 32'($signed(xr[8]) < $signed(xr[9])));
        add_insn(branch_word(F3_BEQ, 5'd11, 5'd11, 32'd12), 1'b1, 5'd0, '0); // Taken
        add_insn(op_imm_word(F3_ADD, 5'd12, 5'd0, 32'd1), 1'b0, 5'd12, 32'd1);
        add_insn(op_imm_word(F3_ADD, 5'd13, 5'd0, 32'd1), 1'b0, 5'd13, 32'd1);
        add_insn(branch_word(F3_BNE, 5'd1, 5'd1, 32'd8), 1'b1, 5'd0, '0);    // Falls through
        add_insn(jal_word(5'd14, 32'd8), 1'b1, 5'd14, 32'((prog_len + 1) * 4));
        add_insn(op_imm_word(F3_ADD, 5'd15, 5'd0, 32'd1), 1'b0, 5'd15, 32'd1);
        add_insn(op_imm_word(F3_ADD, 5'd0, 5'd3, 32'd5), 1'b1, 5'd0, '0);    // Write to x0
        add_insn(jal_word(5'd0, 32'd0), 1'b1, 5'd0, '0);
        repeat (JAL_REPEATS - 1) begin
            exp_pc[num_exp]   = exp_pc[num_exp - 1];
            exp_wren[num_exp] = 1'b0;
            exp_rd[num_exp]   = '0;
            exp_data[num_exp] = '0;
            num_exp++;
        end
    endtask

    rv_core_top i_rv_core_top (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .imem_we_i     (imem_we),
        .imem_waddr_i  (imem_waddr),
        .imem_wdata_i  (imem_wdata),
        .retire_vld_o  (retire_vld),
        .retire_pc_o   (retire_pc),
        .retire_wren_o (retire_wren),
        .retire_rd_o   (retire_rd),
        .retire_data_o (retire_data)
    );

    rv_retire_checker #(
        .NUM_RET     (NUM_RET),
        .CYCLE_LIMIT (CYCLE_LIMIT)
    ) i_checker (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .imem_we_i     (imem_we),
        .retire_vld_i  (retire_vld),
        .retire_pc_i   (retire_pc),
        .retire_wren_i (retire_wren),
        .retire_rd_i   (retire_rd),
        .retire_data_i (retire_data),
        .exp_pc_i      (exp_pc),
        .exp_wren_i    (exp_wren),
        .exp_rd_i      (exp_rd),
        .exp_data_i    (exp_data),
        .done_o        (done),
        .checked_o     (checked),
        .errors_o      (errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n      <= 1'b0;
        imem_we    <= 1'b0;
        imem_waddr <= '0;
        imem_wdata <= '0;
        build_program();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        // Loading begins on the reset release edge
        for (int i = 0; i < PROG_LEN; i++) begin
            imem_we    <= 1'b1;
            imem_waddr <= `RV_IMEM_AW'(i);
            imem_wdata <= prog[i];
            @(posedge clk);
        end
        imem_we <= 1'b0;
        wait (done);
        $display("Retirements checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_core_top.sv
dv/rv_retire_checker.sv
dv/tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f list.f --top-module tb_rv_core -o sim_rv_core

./obj_dir/sim_rv_core | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
exit 0
